/* dv/mem_subsys_chk.sv */
`timescale 1ns/1ps

module mem_subsys_chk (
	input logic                     clk,
	input logic                     rst,
	input logic                     op_valid,
	input logic                     stall,
	input logic                     mmu_req,
	input logic                     wb_valid,
	input logic                     clear,
	input mem_stage_pkg::exc_code_e exc_code
);

	int   fails = 0;
	logic exc_taken;

	// cp0 jumps whenever the stage forwards an exception code
	assign exc_taken = (exc_code != mem_stage_pkg::EC_NONE);

	no_op_in_stall: assert property (@(posedge clk) disable iff (rst) stall |-> !op_valid)
		else begin
			fails++;
			$error("operation strobe while stall is high");
		end

	mmu_req_single: assert property (@(posedge clk) disable iff (rst) mmu_req |=> !mmu_req)
		else begin
			fails++;
			$error("memory request held longer than one cycle");
		end

	exc_has_clear: assert property (@(posedge clk) disable iff (rst) exc_taken |-> clear)
		else begin
			fails++;
			$error("exception jump without pipeline clear");
		end

	no_wb_on_exc: assert property (@(posedge clk) disable iff (rst) !(wb_valid && exc_taken))
		else begin
			fails++;
			$error("writeback in the same cycle as an exception jump");
		end

endmodule

/* dv/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb;

	localparam int          MEM_WORDS   = 256;
	localparam int          MEM_LATENCY = 2;
	localparam logic [31:0] EXC_VECTOR  = 32'h80000180;
	localparam int          NUM_OPS     = 400;
	localparam int          MAX_CYCLES  = NUM_OPS * (MEM_LATENCY + 8) + 100;

	logic                            clk;
	logic                            rst;
	logic                            op_valid;
	mem_stage_pkg::mem_op_e          op_code;
	logic [4:0]                      op_wb_addr;
	logic [31:0]                     op_alu_result;
	mem_stage_pkg::mem_payload_u     op_payload;
	mem_stage_pkg::exc_code_e        op_exc_code;
	logic [31:0]                     op_epc;
	logic [mem_stage_pkg::INT_W-1:0] int_req;
	logic                            stall;
	logic                            wb_valid;
	logic [4:0]                      wb_addr;
	logic [31:0]                     wb_data;
	logic                            exc_jmp_flag;
	logic [31:0]                     exc_jmp_dest;
	logic                            clear;
	logic                            has_int_pending;

	// reference model state
	logic [31:0] m_mem [0:MEM_WORDS-1];
	logic [31:0] m_lo;
	logic [31:0] m_hi;
	logic [31:0] m_status;
	logic [31:0] m_epc;
	logic [31:0] m_badvaddr;
	logic [4:0]  m_code;

	integer seed;
	int     errors;
	int     cycles = 0;
	bit     read_next;

	mem_subsys_top dut (
		.clk(clk), .rst(rst),
		.op_valid(op_valid), .op_code(op_code), .op_wb_addr(op_wb_addr),
		.op_alu_result(op_alu_result), .op_payload(op_payload),
		.op_exc_code(op_exc_code), .op_epc(op_epc), .int_req(int_req),
		.stall(stall), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
		.exc_jmp_flag(exc_jmp_flag), .exc_jmp_dest(exc_jmp_dest), .clear(clear),
		.has_int_pending(has_int_pending)
	);

	bind mem_stage mem_subsys_chk u_chk (
		.clk(clk), .rst(rst), .op_valid(op_valid), .stall(stall),
		.mmu_req(mmu_req), .wb_valid(wb_valid), .clear(clear), .exc_code(exc_code)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: operations did not complete within %0d cycles", MAX_CYCLES);
			$display("operations: %0d, errors: %0d", NUM_OPS, errors);
			$display("Simulation failed");
			$finish;
		end
	end

	// expected CP0 read value with the cause pending bits following the request lines
	function automatic logic [31:0] model_cp0(input logic [4:0] i,
		input logic [mem_stage_pkg::INT_W-1:0] irq);
		case (i)
			mem_stage_pkg::CP0_STATUS:   return m_status;
			mem_stage_pkg::CP0_CAUSE:    return {16'b0, irq, 3'b0, m_code, 2'b0};
			mem_stage_pkg::CP0_EPC:      return m_epc;
			mem_stage_pkg::CP0_BADVADDR: return m_badvaddr;
			default:                     return 32'h0;
		endcase
	endfunction

	// mostly a small aligned window so stores and loads meet
	task automatic pick_addr(output logic [31:0] a);
		int r;
		r = {$random(seed)} % 20;
		a = $random(seed);
		if (r == 0) begin
			a = {22'b0, a[9:0]};
			if (a[1:0] == 2'b00)
				a[0] = 1'b1;
		end else if (r == 1) begin
			a = {a[31:12], 2'b01, a[9:2], 2'b00};
		end else if (r < 6) begin
			a = {22'b0, a[9:2], 2'b00};
		end else begin
			a = {25'b0, a[4:0], 2'b00};
		end
	endtask

	task automatic enter_exception(input logic [4:0] code, input logic [31:0] epc,
		input logic [31:0] bad, input bit is_addr);
		m_status[1] = 1'b1;
		m_epc       = epc;
		m_code      = code;
		if (is_addr)
			m_badvaddr = bad;
	endtask

	task automatic run_one_op();
		int                              r;
		int                              n;
		int                              exp_cycle;
		int                              stall_last;
		bit                              exp_wb;
		bit                              exp_exc;
		bit                              seen;
		bit                              fault;
		logic [31:0]                     a;
		logic [31:0]                     d;
		logic [31:0]                     alu;
		logic [31:0]                     epc;
		logic [31:0]                     exp_data;
		logic [4:0]                      wa;
		logic [4:0]                      idx;
		logic [mem_stage_pkg::INT_W-1:0] irq;
		logic                            exp_int;
		mem_stage_pkg::mem_payload_u     pl;
		mem_stage_pkg::mem_op_e          code;
		mem_stage_pkg::exc_code_e        ec;

		r = {$random(seed)} % 100;
		pick_addr(a);
		d   = $random(seed);
		alu = $random(seed);
		epc = {$random(seed)} & 32'hfffffffc;
		wa  = 5'($random(seed));
		irq = mem_stage_pkg::INT_W'($random(seed));
		pl  = {$random(seed), $random(seed)};
		ec  = (({$random(seed)} % 20) == 0) ? mem_stage_pkg::EC_SYSCALL : mem_stage_pkg::EC_NONE;
		case ({$random(seed)} % 4)
			0:       idx = mem_stage_pkg::CP0_STATUS;
			1:       idx = mem_stage_pkg::CP0_CAUSE;
			2:       idx = mem_stage_pkg::CP0_EPC;
			default: idx = mem_stage_pkg::CP0_BADVADDR;
		endcase

		if (read_next)
			code = mem_stage_pkg::OP_READ_CP0;
		else if (r < 15)
			code = mem_stage_pkg::OP_ALU;
		else if (r < 30)
			code = mem_stage_pkg::OP_LOAD;
		else if (r < 45)
			code = mem_stage_pkg::OP_STORE;
		else if (r < 52)
			code = mem_stage_pkg::OP_MTLO;
		else if (r < 59)
			code = mem_stage_pkg::OP_MTHI;
		else if (r < 66)
			code = mem_stage_pkg::OP_MFLO;
		else if (r < 73)
			code = mem_stage_pkg::OP_MFHI;
		else if (r < 87)
			code = mem_stage_pkg::OP_READ_CP0;
		else
			code = mem_stage_pkg::OP_WRITE_CP0;
		read_next = 1'b0;

		if (code == mem_stage_pkg::OP_LOAD || code == mem_stage_pkg::OP_STORE) begin
			pl.mem.addr  = a;
			pl.mem.wdata = d;
		end else if (code == mem_stage_pkg::OP_WRITE_CP0) begin
			// status only with EXL kept clear so exceptions can be taken again
			pl.cp0.idx   = mem_stage_pkg::CP0_STATUS;
			pl.cp0.wdata = d & ~32'h2;
		end else if (code == mem_stage_pkg::OP_READ_CP0) begin
			pl.cp0.idx = idx;
		end

		// prediction from the model state at issue time
		exp_wb     = 1'b0;
		exp_exc    = 1'b0;
		exp_cycle  = 0;
		stall_last = 0;
		exp_data   = alu;
		fault      = (a[1:0] != 2'b00) || (a[31:2] >= MEM_WORDS);
		if (ec != mem_stage_pkg::EC_NONE) begin
			exp_exc   = 1'b1;
			exp_cycle = 1;
			enter_exception(ec, epc, a, 1'b0);
		end else begin
			case (code)
				mem_stage_pkg::OP_ALU: begin
					exp_wb    = 1'b1;
					exp_cycle = 1;
				end
				mem_stage_pkg::OP_READ_CP0: begin
					exp_wb    = 1'b1;
					exp_cycle = 1;
					exp_data  = model_cp0(idx, irq);
				end
				mem_stage_pkg::OP_WRITE_CP0: m_status = pl.cp0.wdata;
				mem_stage_pkg::OP_LOAD,
				mem_stage_pkg::OP_STORE: begin
					if (fault) begin
						exp_exc    = 1'b1;
						exp_cycle  = 4;
						stall_last = 3;
						if (code == mem_stage_pkg::OP_STORE)
							enter_exception(mem_stage_pkg::EC_ADES, epc, a, 1'b1);
						else
							enter_exception(mem_stage_pkg::EC_ADEL, epc, a, 1'b1);
					end else if (code == mem_stage_pkg::OP_LOAD) begin
						exp_wb     = 1'b1;
						exp_cycle  = MEM_LATENCY + 4;
						stall_last = MEM_LATENCY + 3;
						exp_data   = m_mem[a[31:2]];
					end else begin
						stall_last     = MEM_LATENCY + 3;
						m_mem[a[31:2]] = d;
					end
				end
				mem_stage_pkg::OP_MTLO: begin
					stall_last = 2;
					m_lo       = alu;
				end
				mem_stage_pkg::OP_MTHI: begin
					stall_last = 2;
					m_hi       = alu;
				end
				mem_stage_pkg::OP_MFLO,
				mem_stage_pkg::OP_MFHI: begin
					exp_wb     = 1'b1;
					exp_cycle  = 3;
					stall_last = 2;
					exp_data   = (code == mem_stage_pkg::OP_MFLO) ? m_lo : m_hi;
				end
				default: exp_wb = 1'b0;
			endcase
		end
		if (exp_exc)
			read_next = 1'b1;

		@(posedge clk);
		op_valid      <= 1'b1;
		op_code       <= code;
		op_wb_addr    <= wa;
		op_alu_result <= alu;
		op_payload    <= pl;
		op_exc_code   <= ec;
		op_epc        <= epc;
		int_req       <= irq;
		@(posedge clk);
		op_valid <= 1'b0;

		// cycle n counts from the strobe cycle and is sampled mid-cycle
		n    = 0;
		seen = 1'b0;
		do begin
			@(negedge clk);
			n++;
			if (stall != (n <= stall_last)) begin
				errors++;
				$display("MISMATCH at %0t: op %s stall %b in cycle %0d, exp %b",
					$time, code.name(), stall, n, (n <= stall_last));
			end
			if (clear && !exc_jmp_flag) begin
				errors++;
				$display("pipeline clear without an exception jump for op %s at %0t",
					code.name(), $time);
			end
			if (wb_valid) begin
				seen = 1'b1;
				if (!exp_wb || n != exp_cycle || wb_addr != wa || wb_data != exp_data) begin
					errors++;
					$display("MISMATCH at %0t: op %s wb cycle %0d addr %0d data %h, exp %0d/%0d/%h",
						$time, code.name(), n, wb_addr, wb_data, exp_cycle, wa, exp_data);
				end
			end
			if (exc_jmp_flag) begin
				seen = 1'b1;
				if (!exp_exc || n != exp_cycle || exc_jmp_dest != EXC_VECTOR || !clear) begin
					errors++;
					$display("MISMATCH at %0t: op %s exception cycle %0d dest %h clear %b, exp %0d",
						$time, code.name(), n, exc_jmp_dest, clear, exp_cycle);
				end
			end
		end while ((stall || n <= exp_cycle || n < 2) && n < MEM_LATENCY + 8);

		if ((exp_wb || exp_exc) && !seen) begin
			errors++;
			$display("no writeback or exception strobe seen for op %s at %0t", code.name(), $time);
		end
		if (stall) begin
			errors++;
			$display("stage still stalled after op %s at %0t", code.name(), $time);
		end
		exp_int = ((irq & m_status[15:10]) != '0) && m_status[0] && !m_status[1];
		if (has_int_pending != exp_int) begin
			errors++;
			$display("MISMATCH at %0t: has_int_pending %b, exp %b (status %h, int_req %b)",
				$time, has_int_pending, exp_int, m_status, irq);
		end
	endtask

	initial begin
		seed          = 97432;
		errors        = 0;
		read_next     = 1'b0;
		m_lo          = '0;
		m_hi          = '0;
		m_status      = '0;
		m_epc         = '0;
		m_badvaddr    = '0;
		m_code        = '0;
		rst           = 1'b1;
		op_valid      = 1'b0;
		op_code       = mem_stage_pkg::OP_NONE;
		op_wb_addr    = '0;
		op_alu_result = '0;
		op_payload    = '0;
		op_exc_code   = mem_stage_pkg::EC_NONE;
		op_epc        = '0;
		int_req       = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			m_mem[i] = '0;

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (stall || wb_valid || exc_jmp_flag || clear) begin
			errors++;
			$display("outputs not idle after reset at %0t", $time);
		end

		for (int i = 0; i < NUM_OPS; i++)
			run_one_op();

		errors += dut.u_stage.u_chk.fails;
		$display("operations: %0d, errors: %0d", NUM_OPS, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* logic/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs #(
	parameter logic [31:0] EXC_VECTOR = 32'h80000180
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            we,
	input  logic [4:0]                      waddr,
	input  logic [31:0]                     wdata,
	input  mem_stage_pkg::exc_code_e        exc_code,
	input  logic [31:0]                     exc_epc,
	input  logic [31:0]                     exc_badvaddr,
	input  logic [mem_stage_pkg::INT_W-1:0] int_req,
	output logic [31:0]                     status,
	output logic [31:0]                     cause,
	output logic [31:0]                     epc,
	output logic [31:0]                     badvaddr,
	output logic                            exc_jmp_flag,
	output logic [31:0]                     exc_jmp_dest,
	output logic                            has_int_pending
);

	logic [4:0] cause_code;
	logic       addr_exc;

	assign exc_jmp_flag = (exc_code != mem_stage_pkg::EC_NONE);
	assign exc_jmp_dest = EXC_VECTOR;

	// only address errors carry a meaningful bad address
	assign addr_exc = (exc_code == mem_stage_pkg::EC_ADEL) ||
		(exc_code == mem_stage_pkg::EC_ADES);

	// pending bits 15:10 track the request lines directly
	assign cause = {16'b0, int_req, 3'b0, cause_code, 2'b0};

	// mask in 15:10, IE in bit 0, EXL in bit 1
	assign has_int_pending = ((int_req & status[15:10]) != '0) && status[0] && !status[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			status     <= '0;
			epc        <= '0;
			badvaddr   <= '0;
			cause_code <= '0;
		end else if (exc_jmp_flag) begin
			// exception entry has priority over a software write
			status[1]  <= 1'b1;
			epc        <= exc_epc;
			cause_code <= exc_code;
			if (addr_exc)
				badvaddr <= exc_badvaddr;
		end else if (we) begin
			case (waddr)
				mem_stage_pkg::CP0_STATUS:   status <= wdata;
				mem_stage_pkg::CP0_EPC:      epc <= wdata;
				mem_stage_pkg::CP0_BADVADDR: badvaddr <= wdata;
				// cause is read only
				default: status <= status;
			endcase
		end
	end

endmodule

/* logic/data_mmu.sv */
`timescale 1ns/1ps

module data_mmu #(
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 2
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     req,
	input  logic                     write,
	input  logic [31:0]              addr,
	input  logic [31:0]              wdata,
	output logic                     busy,
	output logic                     done,
	output logic [31:0]              rdata,
	output mem_stage_pkg::exc_code_e exc
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	logic [31:0]      mem [0:MEM_WORDS-1];
	logic [CNT_W-1:0] cnt;
	logic [IDX_W-1:0] idx_q;
	logic             write_q;
	logic [31:0]      wdata_q;
	logic             fault;
	logic             access;

	// word access only, inside the implemented range
	assign fault = (addr[1:0] != 2'b00) || (addr[31:2] >= MEM_WORDS);

	// last latency cycle performs the array access
	assign access = busy && (cnt == CNT_W'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
			exc  <= mem_stage_pkg::EC_NONE;
		end else begin
			done <= 1'b0;
			exc  <= mem_stage_pkg::EC_NONE;
			if (busy) begin
				if (access) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					cnt <= cnt - CNT_W'(1);
				end
			end else if (req) begin
				if (fault) begin
					exc <= write ? mem_stage_pkg::EC_ADES : mem_stage_pkg::EC_ADEL;
				end else begin
					busy <= 1'b1;
					cnt  <= CNT_W'(MEM_LATENCY);
				end
			end
		end
	end

	// request captured at issue, held through the latency count
	always_ff @(posedge clk) begin
		if (req && !busy) begin
			idx_q   <= addr[IDX_W+1:2];
			write_q <= write;
			wdata_q <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end else if (access && write_q) begin
			mem[idx_q] <= wdata_q;
		end
	end

	always_ff @(posedge clk) begin
		if (access && !write_q)
			rdata <= mem[idx_q];
	end

endmodule

/* logic/lohi_regs.sv */
`timescale 1ns/1ps

module lohi_regs (
	input  logic                     clk,
	input  logic                     rst,
	input  mem_stage_pkg::lohi_opt_e opt,
	input  logic [31:0]              wdata,
	input  logic                     rd,
	output logic [63:0]              value,
	output logic                     ready
);

	logic [31:0] lo;
	logic [31:0] hi;

	assign value = {hi, lo};

	always_ff @(posedge clk) begin
		if (rst) begin
			lo    <= '0;
			hi    <= '0;
			ready <= 1'b0;
		end else begin
			// every request is answered in the next cycle
			ready <= rd || (opt != mem_stage_pkg::LOHI_NONE);
			case (opt)
				mem_stage_pkg::LOHI_WRITE_LO: lo <= wdata;
				mem_stage_pkg::LOHI_WRITE_HI: hi <= wdata;
				default: lo <= lo;
			endcase
		end
	end

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
	input  logic                        clk,
	input  logic                        rst,

	input  logic                        op_valid,
	input  mem_stage_pkg::mem_op_e      op_code,
	input  logic [4:0]                  op_wb_addr,
	input  logic [31:0]                 op_alu_result,
	input  mem_stage_pkg::mem_payload_u op_payload,
	input  mem_stage_pkg::exc_code_e    op_exc_code,
	input  logic [31:0]                 op_epc,

	output logic                        stall,
	output logic                        wb_valid,
	output logic [4:0]                  wb_addr,
	output logic [31:0]                 wb_data,

	output logic                        mmu_req,
	output logic                        mmu_write,
	output logic [31:0]                 mmu_addr,
	output logic [31:0]                 mmu_wdata,
	input  logic                        mmu_busy,
	input  logic                        mmu_done,
	input  logic [31:0]                 mmu_rdata,
	input  mem_stage_pkg::exc_code_e    mmu_exc,

	output mem_stage_pkg::lohi_opt_e    lohi_opt,
	output logic [31:0]                 lohi_wdata,
	output logic                        lohi_rd,
	input  logic                        lohi_ready,
	input  logic [63:0]                 lohi_value,

	output logic                        cp0_we,
	output logic [4:0]                  cp0_waddr,
	output logic [31:0]                 cp0_wdata,

	output mem_stage_pkg::exc_code_e    exc_code,
	output logic [31:0]                 exc_epc,
	output logic [31:0]                 exc_badvaddr,
	input  logic [31:0]                 cp0_status,
	input  logic [31:0]                 cp0_cause,
	input  logic [31:0]                 cp0_epc,
	input  logic [31:0]                 cp0_badvaddr,

	output logic                        clear
);

	localparam logic [1:0] READY     = 2'd0;
	localparam logic [1:0] WAIT_MMU  = 2'd1;
	localparam logic [1:0] WAIT_LOHI = 2'd2;

	logic [1:0]               state;
	mem_stage_pkg::mem_op_e   op_q;

	// memory answers are taken one cycle late
	logic                     mmu_done_q;
	mem_stage_pkg::exc_code_e mmu_exc_q;
	logic [31:0]              mmu_rdata_q;

	logic [31:0] cp0_rdata;
	logic [31:0] lohi_sel;
	logic        accept;
	logic        mmu_fault;
	logic        mmu_complete;
	logic        lohi_complete;

	assign stall = (state != READY);

	assign accept        = (state == READY) && op_valid;
	assign mmu_fault     = (state == WAIT_MMU) && (mmu_exc_q != mem_stage_pkg::EC_NONE);
	assign mmu_complete  = (state == WAIT_MMU) && (mmu_exc_q == mem_stage_pkg::EC_NONE) &&
		mmu_done_q && !mmu_busy;
	assign lohi_complete = (state == WAIT_LOHI) && lohi_ready;

	assign lohi_sel = (op_q == mem_stage_pkg::OP_MFHI) ? lohi_value[63:32] : lohi_value[31:0];

	// CP0 read port, indexed through the cp0 view of the payload
	always_comb begin
		case (op_payload.cp0.idx)
			mem_stage_pkg::CP0_STATUS:   cp0_rdata = cp0_status;
			mem_stage_pkg::CP0_CAUSE:    cp0_rdata = cp0_cause;
			mem_stage_pkg::CP0_EPC:      cp0_rdata = cp0_epc;
			mem_stage_pkg::CP0_BADVADDR: cp0_rdata = cp0_badvaddr;
			default:                     cp0_rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= READY;
			wb_valid   <= 1'b0;
			mmu_req    <= 1'b0;
			lohi_opt   <= mem_stage_pkg::LOHI_NONE;
			lohi_rd    <= 1'b0;
			cp0_we     <= 1'b0;
			exc_code   <= mem_stage_pkg::EC_NONE;
			clear      <= 1'b0;
			mmu_done_q <= 1'b0;
			mmu_exc_q  <= mem_stage_pkg::EC_NONE;
		end else begin
			// strobes last one cycle
			wb_valid   <= 1'b0;
			mmu_req    <= 1'b0;
			lohi_opt   <= mem_stage_pkg::LOHI_NONE;
			lohi_rd    <= 1'b0;
			cp0_we     <= 1'b0;
			exc_code   <= mem_stage_pkg::EC_NONE;
			clear      <= 1'b0;
			mmu_done_q <= mmu_done;
			mmu_exc_q  <= mmu_exc;

			case (state)
				READY: begin
					if (accept) begin
						if (op_exc_code != mem_stage_pkg::EC_NONE) begin
							// operation already faulted upstream, only report it
							exc_code <= op_exc_code;
							clear    <= 1'b1;
						end else begin
							case (op_code)
								mem_stage_pkg::OP_ALU,
								mem_stage_pkg::OP_READ_CP0: wb_valid <= 1'b1;
								mem_stage_pkg::OP_WRITE_CP0: cp0_we <= 1'b1;
								mem_stage_pkg::OP_LOAD,
								mem_stage_pkg::OP_STORE: begin
									mmu_req <= 1'b1;
									state   <= WAIT_MMU;
								end
								mem_stage_pkg::OP_MFLO,
								mem_stage_pkg::OP_MFHI: begin
									lohi_rd <= 1'b1;
									state   <= WAIT_LOHI;
								end
								mem_stage_pkg::OP_MTLO: begin
									lohi_opt <= mem_stage_pkg::LOHI_WRITE_LO;
									state    <= WAIT_LOHI;
								end
								mem_stage_pkg::OP_MTHI: begin
									lohi_opt <= mem_stage_pkg::LOHI_WRITE_HI;
									state    <= WAIT_LOHI;
								end
								default: state <= READY;
							endcase
						end
					end
				end
				WAIT_MMU: begin
					if (mmu_fault) begin
						exc_code <= mmu_exc_q;
						clear    <= 1'b1;
						state    <= READY;
					end else if (mmu_complete) begin
						wb_valid <= !mmu_write;
						state    <= READY;
					end
				end
				WAIT_LOHI: begin
					if (lohi_complete) begin
						wb_valid <= (op_q == mem_stage_pkg::OP_MFLO) ||
							(op_q == mem_stage_pkg::OP_MFHI);
						state    <= READY;
					end
				end
				default: state <= READY;
			endcase
		end
	end

	// operands and results
	always_ff @(posedge clk) begin
		mmu_rdata_q <= mmu_rdata;
		if (accept) begin
			op_q       <= op_code;
			wb_addr    <= op_wb_addr;
			mmu_write  <= (op_code == mem_stage_pkg::OP_STORE);
			mmu_addr   <= op_payload.mem.addr;
			mmu_wdata  <= op_payload.mem.wdata;
			cp0_waddr  <= op_payload.cp0.idx;
			cp0_wdata  <= op_payload.cp0.wdata;
			lohi_wdata <= op_alu_result;
			// a later memory fault reports this epc and address as well
			exc_epc      <= op_epc;
			exc_badvaddr <= op_payload.mem.addr;
			if (op_code == mem_stage_pkg::OP_READ_CP0)
				wb_data <= cp0_rdata;
			else
				wb_data <= op_alu_result;
		end else if (mmu_complete) begin
			wb_data <= mmu_rdata_q;
		end else if (lohi_complete) begin
			wb_data <= lohi_sel;
		end
	end

endmodule

/* logic/mem_stage_pkg.sv */
package mem_stage_pkg;

	// width of the interrupt request lines and the status mask field
	localparam int INT_W = 6;

	// operation codes handed to the memory stage
	typedef enum logic [3:0] {
		OP_NONE      = 4'd0,
		OP_ALU       = 4'd1,
		OP_LOAD      = 4'd2,
		OP_STORE     = 4'd3,
		OP_MFLO      = 4'd4,
		OP_MFHI      = 4'd5,
		OP_MTLO      = 4'd6,
		OP_MTHI      = 4'd7,
		OP_READ_CP0  = 4'd8,
		OP_WRITE_CP0 = 4'd9
	} mem_op_e;

	// MIPS cause codes; interrupt is code 0, so "no exception" takes the top value
	typedef enum logic [4:0] {
		EC_INT     = 5'd0,
		EC_ADEL    = 5'd4,
		EC_ADES    = 5'd5,
		EC_SYSCALL = 5'd8,
		EC_RI      = 5'd10,
		EC_NONE    = 5'd31
	} exc_code_e;

	// LO/HI write option
	typedef enum logic [1:0] {
		LOHI_NONE     = 2'd0,
		LOHI_WRITE_LO = 2'd1,
		LOHI_WRITE_HI = 2'd2
	} lohi_opt_e;

	// CP0 register indices
	localparam logic [4:0] CP0_BADVADDR = 5'd8;
	localparam logic [4:0] CP0_STATUS   = 5'd12;
	localparam logic [4:0] CP0_CAUSE    = 5'd13;
	localparam logic [4:0] CP0_EPC      = 5'd14;

	// operand payload, read as a memory access or as a CP0 access
	typedef union packed {
		struct packed {
			logic [31:0] addr;
			logic [31:0] wdata;
		} mem;
		struct packed {
			logic [26:0] pad;
			logic [4:0]  idx;
			logic [31:0] wdata;
		} cp0;
	} mem_payload_u;

endpackage

/* logic/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
	parameter int          MEM_WORDS   = 256,
	parameter int          MEM_LATENCY = 2,
	parameter logic [31:0] EXC_VECTOR  = 32'h80000180
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            op_valid,
	input  mem_stage_pkg::mem_op_e          op_code,
	input  logic [4:0]                      op_wb_addr,
	input  logic [31:0]                     op_alu_result,
	input  mem_stage_pkg::mem_payload_u     op_payload,
	input  mem_stage_pkg::exc_code_e        op_exc_code,
	input  logic [31:0]                     op_epc,
	input  logic [mem_stage_pkg::INT_W-1:0] int_req,
	output logic                            stall,
	output logic                            wb_valid,
	output logic [4:0]                      wb_addr,
	output logic [31:0]                     wb_data,
	output logic                            exc_jmp_flag,
	output logic [31:0]                     exc_jmp_dest,
	output logic                            clear,
	output logic                            has_int_pending
);

	logic                     mmu_req;
	logic                     mmu_write;
	logic [31:0]              mmu_addr;
	logic [31:0]              mmu_wdata;
	logic                     mmu_busy;
	logic                     mmu_done;
	logic [31:0]              mmu_rdata;
	mem_stage_pkg::exc_code_e mmu_exc;

	mem_stage_pkg::lohi_opt_e lohi_opt;
	logic [31:0]              lohi_wdata;
	logic                     lohi_rd;
	logic                     lohi_ready;
	logic [63:0]              lohi_value;

	logic                     cp0_we;
	logic [4:0]               cp0_waddr;
	logic [31:0]              cp0_wdata;
	mem_stage_pkg::exc_code_e exc_code;
	logic [31:0]              exc_epc;
	logic [31:0]              exc_badvaddr;
	logic [31:0]              cp0_status;
	logic [31:0]              cp0_cause;
	logic [31:0]              cp0_epc;
	logic [31:0]              cp0_badvaddr;

	mem_stage u_stage (
		.clk(clk), .rst(rst),
		.op_valid(op_valid), .op_code(op_code), .op_wb_addr(op_wb_addr),
		.op_alu_result(op_alu_result), .op_payload(op_payload),
		.op_exc_code(op_exc_code), .op_epc(op_epc),
		.stall(stall), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
		.mmu_req(mmu_req), .mmu_write(mmu_write), .mmu_addr(mmu_addr),
		.mmu_wdata(mmu_wdata), .mmu_busy(mmu_busy), .mmu_done(mmu_done),
		.mmu_rdata(mmu_rdata), .mmu_exc(mmu_exc),
		.lohi_opt(lohi_opt), .lohi_wdata(lohi_wdata), .lohi_rd(lohi_rd),
		.lohi_ready(lohi_ready), .lohi_value(lohi_value),
		.cp0_we(cp0_we), .cp0_waddr(cp0_waddr), .cp0_wdata(cp0_wdata),
		.exc_code(exc_code), .exc_epc(exc_epc), .exc_badvaddr(exc_badvaddr),
		.cp0_status(cp0_status), .cp0_cause(cp0_cause), .cp0_epc(cp0_epc),
		.cp0_badvaddr(cp0_badvaddr), .clear(clear)
	);

	cp0_regs #(.EXC_VECTOR(EXC_VECTOR)) u_cp0 (
		.clk(clk), .rst(rst),
		.we(cp0_we), .waddr(cp0_waddr), .wdata(cp0_wdata),
		.exc_code(exc_code), .exc_epc(exc_epc), .exc_badvaddr(exc_badvaddr),
		.int_req(int_req),
		.status(cp0_status), .cause(cp0_cause), .epc(cp0_epc), .badvaddr(cp0_badvaddr),
		.exc_jmp_flag(exc_jmp_flag), .exc_jmp_dest(exc_jmp_dest),
		.has_int_pending(has_int_pending)
	);

	lohi_regs u_lohi (
		.clk(clk), .rst(rst),
		.opt(lohi_opt), .wdata(lohi_wdata), .rd(lohi_rd),
		.value(lohi_value), .ready(lohi_ready)
	);

	data_mmu #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) u_mmu (
		.clk(clk), .rst(rst),
		.req(mmu_req), .write(mmu_write), .addr(mmu_addr), .wdata(mmu_wdata),
		.busy(mmu_busy), .done(mmu_done), .rdata(mmu_rdata), .exc(mmu_exc)
	);

endmodule

/* src.f */
logic/mem_stage_pkg.sv
logic/mem_stage.sv
logic/cp0_regs.sv
logic/lohi_regs.sv
logic/data_mmu.sv
logic/mem_subsys_top.sv
dv/mem_subsys_chk.sv
dv/mem_subsys_tb.sv
